// ==== uart_serial.f ====
verilog/uart_pkg.sv
verilog/baud_gen.sv
verilog/sync_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_tx_fifo.sv
verilog/uart_wb_regs.sv
verilog/uart_top.sv
tb/tb_uart_top.sv

// ==== tb/tb_uart_top.sv ====
`timescale 1ns/1ps

module tb_uart_top;

	localparam int baud_div    = 4;
	localparam int fifo_depth  = 8;
	localparam int bit_clks    = 4 * baud_div;  // clocks per serial bit
	localparam int bit_ns      = bit_clks * 40;
	localparam int frame_clks  = 11 * bit_clks;  // frame plus one idle bit
	localparam int frame_count = 25;             // 10 frames on txd and 15 on rxd
	localparam int cycle_limit = 2 * frame_count * frame_clks + 2000;

	logic       clk;
	logic       reset;
	logic       cyc;
	logic       stb;
	logic       we;
	logic [1:0] adr;
	logic [7:0] dat_w;
	logic       rxd;
	logic [7:0] dat_r;
	logic       ack;
	logic       txd;

	int          check_errors;    // wrong values
	int          protocol_errors; // framing and sequencing problems
	int          cycles;
	logic [15:0] lfsr;
	int          tx_count;        // model of tx fifo occupancy
	int          rx_count;        // model of rx fifo occupancy
	bit          ovf_model;
	logic [7:0]  tx_expected[$];  // bytes still to appear on txd
	logic [7:0]  rx_expected[$];  // bytes waiting in the rx fifo

	uart_top #(.baud_div(baud_div), .fifo_depth(fifo_depth)) dut0 (
		.clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .rxd(rxd), .dat_r(dat_r), .ack(ack), .txd(txd)
	);

	always #20 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("sim failed");
			$finish;
		end
	end

	// expected status word from the model state
	function automatic logic [7:0] expected_status(input int txc, input int rxc, input bit ovf);
		logic [7:0] s;
		s = '0;
		s[uart_pkg::stat_tx_space] = (txc < fifo_depth);
		s[uart_pkg::stat_rx_avail] = (rxc > 0);
		s[uart_pkg::stat_rx_ovf]   = ovf;
		return s;
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic next_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr); // one step per bit
			b[i] = lfsr[0];
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
			check_errors++;
		end
	endtask

	// one wishbone classic access, held until ack
	task automatic bus_access(input logic write, input logic [1:0] addr,
	                          input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		@(posedge clk);
		#2;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = write;
		adr   = addr;
		dat_w = wdata;
		waited = 0;
		do begin
			@(posedge clk);
			#1; // ack and dat_r settle after the edge
			waited++;
		end while (ack !== 1'b1);
		// ack one clock after the request
		assert (waited == 1) else begin
			$display("CHECK FAILED at %0t ns: ack after %0d cycles", $time, waited);
			check_errors++;
		end
		rdata = dat_r;
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		@(posedge clk);
		#1;
		assert (ack === 1'b0) else begin // single cycle pulse
			$display("CHECK FAILED at %0t ns: ack held longer than one cycle", $time);
			check_errors++;
		end
	endtask

	task automatic check_status(input string what);
		logic [7:0] r;
		bus_access(1'b0, uart_pkg::adr_status, 8'h00, r);
		check_byte(r, expected_status(tx_count, rx_count, ovf_model), what);
	endtask

	task automatic write_tx(input logic [7:0] b);
		logic [7:0] r;
		tx_expected.push_back(b);
		bus_access(1'b1, uart_pkg::adr_data, b, r);
	endtask

	// pop one rx byte, an empty fifo reads back zero
	task automatic read_rx(input string what);
		logic [7:0] r;
		logic [7:0] exp;
		exp = 8'h00;
		if (rx_expected.size() != 0) begin
			exp = rx_expected.pop_front();
			rx_count--;
		end
		bus_access(1'b0, uart_pkg::adr_data, 8'h00, r);
		check_byte(r, exp, what);
	endtask

	// 8-N-1 frame on rxd
	task automatic send_frame(input logic [7:0] b, input bit stop_ok);
		@(posedge clk);
		#2;
		rxd = 1'b0; // start
		#bit_ns;
		for (int i = 0; i < 8; i++) begin
			rxd = b[i];
			#bit_ns;
		end
		if (stop_ok) begin
			rxd = 1'b1;
			#bit_ns;
		end else begin
			// low only over the sampled first half
			// a longer low would read as a fresh start bit
			rxd = 1'b0;
			#(bit_ns / 2);
			rxd = 1'b1;
			#(bit_ns / 2);
		end
	endtask

	task automatic wait_tx_drained();
		while (tx_expected.size() != 0)
			@(posedge clk);
		#(2 * bit_ns); // stop bit ends and the transmitter goes ready
	endtask

	// txd decoder, samples at bit centers away from clock edges
	initial begin : txd_decoder
		logic [7:0] b;
		@(negedge reset);
		forever begin
			@(negedge txd);
			#(bit_ns / 2 + 10);
			assert (txd === 1'b0) else begin
				$display("txd start bit did not stay low at %0t ns", $time);
				protocol_errors++;
			end
			for (int i = 0; i < 8; i++) begin
				#bit_ns;
				b[i] = txd; // lsb first
			end
			#bit_ns;
			assert (txd === 1'b1) else begin
				$display("txd stop bit was low at %0t ns", $time);
				protocol_errors++;
			end
			assert (tx_expected.size() != 0) else begin
				$display("txd sent byte %02h that was never written", b);
				protocol_errors++;
			end
			if (tx_expected.size() != 0)
				check_byte(b, tx_expected.pop_front(), "txd byte");
		end
	end

	initial begin
		logic [7:0] b;
		clk             = 1'b0;
		reset           = 1'b1;
		cyc             = 1'b0;
		stb             = 1'b0;
		we              = 1'b0;
		adr             = 2'd0;
		dat_w           = 8'h00;
		rxd             = 1'b1; // idle line
		check_errors    = 0;
		protocol_errors = 0;
		cycles          = 0;
		lfsr            = 16'd57;
		tx_count        = 0;
		rx_count        = 0;
		ovf_model       = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// line rests high and status is idle after reset
		repeat (2 * bit_clks) begin
			@(posedge clk);
			#1;
			assert (txd === 1'b1) else begin
				$display("txd left the idle level after reset at %0t ns", $time);
				protocol_errors++;
			end
		end
		check_status("status after reset");

		// single byte out
		next_byte(b);
		write_tx(b);
		wait_tx_drained();

		// first byte goes straight to the idle transmitter, eight fill the fifo
		for (int i = 0; i < fifo_depth + 1; i++) begin
			next_byte(b);
			write_tx(b);
		end
		tx_count = fifo_depth;
		check_status("status with tx fifo full");
		wait_tx_drained();
		tx_count = 0;
		check_status("status after tx drain");

		// bytes in on rxd and back out through the data register
		for (int i = 0; i < 4; i++) begin
			next_byte(b);
			send_frame(b, 1'b1);
			rx_expected.push_back(b);
			rx_count++;
			check_status("status while receiving");
		end
		while (rx_expected.size() != 0) begin
			read_rx("rx byte");
			check_status("status while reading");
		end
		read_rx("read of empty rx fifo");

		// bad stop bit drops the byte, the next good one still lands
		next_byte(b);
		send_frame(b, 1'b0);
		#(2 * bit_ns);
		check_status("status after bad stop bit");
		next_byte(b);
		send_frame(b, 1'b1);
		rx_expected.push_back(b);
		rx_count++;
		check_status("status after good frame");
		read_rx("rx byte after bad frame");

		// nine bytes into an eight deep fifo
		for (int i = 0; i < fifo_depth + 1; i++) begin
			next_byte(b);
			send_frame(b, 1'b1);
			if (rx_count < fifo_depth) begin
				rx_expected.push_back(b);
				rx_count++;
			end else begin
				ovf_model = 1'b1; // ninth byte lost
			end
		end
		check_status("status with overflow");
		ovf_model = 1'b0; // cleared by that read
		check_status("status after overflow clear");
		while (rx_expected.size() != 0)
			read_rx("rx byte after overflow");
		check_status("status at end");

		$display("errors: %0d check, %0d protocol", check_errors, protocol_errors);
		if (check_errors == 0 && protocol_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ps

module uart_top #(
	parameter int baud_div   = 4, // clk cycles per quarter bit
	parameter int fifo_depth = 8  // entries per fifo, power of two
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [1:0]                      adr,
	input  logic [uart_pkg::byte_width-1:0] dat_w,
	input  logic                            rxd,   // idles high
	output logic [uart_pkg::byte_width-1:0] dat_r,
	output logic                            ack,
	output logic                            txd    // idles high
);

	logic baud_x4;
	logic baud_x1;
	logic [uart_pkg::byte_width-1:0] tx_data;    // bus byte to tx fifo
	logic tx_strobe;
	logic tx_ready;                              // tx fifo space
	logic [uart_pkg::byte_width-1:0] rx_byte;    // uart_rx output
	logic rx_byte_strobe;
	logic [uart_pkg::byte_width-1:0] rx_head;    // rx fifo registered output
	logic rx_avail;
	logic rx_space;
	logic rx_pop;

	baud_gen #(.baud_div(baud_div)) baud (
		.clk(clk), .reset(reset), .baud_x4(baud_x4), .baud_x1(baud_x1)
	);

	uart_tx_fifo #(.fifo_depth(fifo_depth)) tx_path (
		.clk(clk), .reset(reset), .baud_x1(baud_x1),
		.data(tx_data), .data_strobe(tx_strobe),
		.serial(txd), .ready(tx_ready)
	);

	uart_rx rx (
		.clk(clk), .reset(reset), .baud_x4(baud_x4), .serial(rxd),
		.data(rx_byte), .data_strobe(rx_byte_strobe)
	);

	// receive fifo, a full fifo drops the byte and the slave flags overflow
	sync_fifo #(.fifo_depth(fifo_depth), .width(uart_pkg::byte_width)) rx_fifo (
		.clk(clk), .reset(reset),
		.write_data(rx_byte), .write_strobe(rx_byte_strobe),
		.read_strobe(rx_pop), .read_data(rx_head),
		.data_available(rx_avail), .space_available(rx_space)
	);

	uart_wb_regs regs (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w),
		.dat_r(dat_r), .ack(ack),
		.tx_ready(tx_ready), .tx_data(tx_data), .tx_strobe(tx_strobe),
		.rx_data(rx_head), .rx_avail(rx_avail), .rx_space(rx_space),
		.rx_strobe(rx_byte_strobe), .rx_pop(rx_pop)
	);

endmodule

// ==== verilog/uart_wb_regs.sv ====
`timescale 1ns/1ps

module uart_wb_regs (
	input  logic                            clk,
	input  logic                            reset,
	// wishbone classic slave
	input  logic                            cyc,
	input  logic                            stb,
	input  logic                            we,
	input  logic [1:0]                      adr,
	input  logic [uart_pkg::byte_width-1:0] dat_w,
	output logic [uart_pkg::byte_width-1:0] dat_r, // valid while ack
	output logic                            ack,
	// transmit fifo
	input  logic                            tx_ready,  // space in tx fifo
	output logic [uart_pkg::byte_width-1:0] tx_data,
	output logic                            tx_strobe, // push
	// receive fifo
	input  logic [uart_pkg::byte_width-1:0] rx_data,   // registered fifo output
	input  logic                            rx_avail,
	input  logic                            rx_space,
	input  logic                            rx_strobe, // byte arriving from uart_rx
	output logic                            rx_pop
);

	logic req;       // new request, the ack cycle is skipped
	logic wr_data;
	logic rd_data;
	logic rd_stat;
	logic ovf;       // sticky overflow
	logic sel_rx;    // ack cycle returns the popped byte
	logic sel_stat;  // ack cycle returns the status word
	logic [uart_pkg::byte_width-1:0] stat_now; // live status
	logic [uart_pkg::byte_width-1:0] stat_r;   // status captured at the request

	assign req     = cyc && stb && !ack;
	assign wr_data = req && we && (adr == uart_pkg::adr_data);
	assign rd_data = req && !we && (adr == uart_pkg::adr_data);
	assign rd_stat = req && !we && (adr == uart_pkg::adr_status);

	// push only with space, a full fifo drops the byte but still acks
	assign tx_data   = dat_w;
	assign tx_strobe = wr_data && tx_ready;

	// pop in the request cycle so the fifo output is ready in the ack cycle
	assign rx_pop = rd_data && rx_avail;

	always_comb begin
		stat_now = '0;
		stat_now[uart_pkg::stat_tx_space] = tx_ready;
		stat_now[uart_pkg::stat_rx_avail] = rx_avail;
		stat_now[uart_pkg::stat_rx_ovf]   = ovf;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ack      <= 1'b0;
			ovf      <= 1'b0;
			sel_rx   <= 1'b0;
			sel_stat <= 1'b0;
		end else begin
			ack      <= req; // exactly one cycle, next cycle req is masked
			sel_rx   <= rx_pop; // empty fifo reads back zero
			sel_stat <= rd_stat;
			if (rx_strobe && !rx_space)
				ovf <= 1'b1; // lost byte, wins over a clear in the same cycle
			else if (rd_stat)
				ovf <= 1'b0; // read clears
		end
	end

	// status snapshot, taken with the overflow value before the clear
	always_ff @(posedge clk) begin
		if (rd_stat)
			stat_r <= stat_now;
	end

	// read mux, writes and unmapped addresses return zero
	always_comb begin
		if (sel_rx)
			dat_r = rx_data;
		else if (sel_stat)
			dat_r = stat_r;
		else
			dat_r = '0;
	end

endmodule

// ==== verilog/uart_tx_fifo.sv ====
`timescale 1ns/1ps

module uart_tx_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            baud_x1,
	input  logic [uart_pkg::byte_width-1:0] data,        // byte from the bus
	input  logic                            data_strobe, // bus push
	output logic                            serial,      // txd
	output logic                            ready        // fifo has space
);

	logic [uart_pkg::byte_width-1:0] fifo_data; // registered head of the fifo
	logic fifo_avail;
	logic fifo_read;  // pop, combinational
	logic tx_load;    // load into uart_tx, one cycle after the pop
	logic tx_ready;   // transmitter idle

	sync_fifo #(
		.fifo_depth(fifo_depth),
		.width     (uart_pkg::byte_width)
	) buffer (
		.clk            (clk),
		.reset          (reset),
		.write_data     (data),
		.write_strobe   (data_strobe),
		.read_strobe    (fifo_read),
		.read_data      (fifo_data),
		.data_available (fifo_avail),
		.space_available(ready)
	);

	uart_tx txd (
		.clk        (clk),
		.reset      (reset),
		.baud_x1    (baud_x1),
		.data       (fifo_data), // popped byte is valid while tx_load
		.data_strobe(tx_load),
		.serial     (serial),
		.ready      (tx_ready)
	);

	// drain, held off during a bus push and while a load is in flight
	assign fifo_read = fifo_avail && tx_ready && !data_strobe && !tx_load;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			tx_load <= 1'b0;
		else
			tx_load <= fifo_read; // tx_ready drops after this load
	end

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            baud_x4,     // four strobes per bit
	input  logic                            serial,      // asynchronous line, idles high
	output logic [uart_pkg::byte_width-1:0] data,        // valid while data_strobe
	output logic                            data_strobe  // one cycle, good frames only
);

	localparam int stop_count = uart_pkg::byte_width + 1; // bit index of the stop bit

	// two flop synchronizer into the clk domain
	logic serial_meta;
	logic serial_sync;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			serial_meta <= 1'b1; // line idles high
			serial_sync <= 1'b1;
		end else begin
			serial_meta <= serial;
			serial_sync <= serial_meta;
		end
	end

	// state is {bit count, phase}, four phases per bit
	logic [5:0] state;
	logic [3:0] bit_count;
	logic [1:0] bit_phase;
	logic [uart_pkg::byte_width:0] shiftreg; // data plus the last sampled bit
	logic sampling;
	logic start_bit;
	logic stop_bit;
	logic waiting;
	logic error;

	assign bit_count = state[5:2];
	assign bit_phase = state[1:0];
	assign sampling  = (bit_phase == 2'd1); // sample near bit center
	assign start_bit = (bit_count == 4'd0) && sampling;
	assign stop_bit  = (bit_count == 4'(stop_count)) && sampling;
	assign waiting   = (state == 6'd0) && serial_sync; // line idle, no edge yet
	// start must still be low, stop must be high
	assign error     = (start_bit && serial_sync) || (stop_bit && !serial_sync);

	assign data = shiftreg[uart_pkg::byte_width-1:0]; // stop bit sits above

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state       <= 6'd0;
			data_strobe <= 1'b0;
		end else if (baud_x4) begin
			if (waiting || error || stop_bit)
				state <= 6'd0; // back to hunting for a start edge
			else
				state <= state + 6'd1;
			data_strobe <= stop_bit && !error;
		end else begin
			data_strobe <= 1'b0;
		end
	end

	// payload shifter, msb first in so lsb lands at bit 0
	always_ff @(posedge clk) begin
		if (baud_x4 && sampling)
			shiftreg <= {serial_sync, shiftreg[uart_pkg::byte_width:1]};
	end

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           baud_x1,     // one pulse per bit period
	input  logic [uart_pkg::byte_width-1:0] data,
	input  logic                           data_strobe, // load data, only while ready
	output logic                           serial,      // idles high
	output logic                           ready        // can take another byte
);

	// stop bit, data, start bit, shifted out from bit 0
	// the stop bit doubles as the busy flag, all zero means idle
	logic [uart_pkg::byte_width+1:0] shiftreg;

	// inverted line register, one bit of lookahead behind shiftreg
	// reset value zero keeps the line high
	logic serial_r;

	assign serial = !serial_r;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shiftreg <= '0;
			serial_r <= 1'b0;
			ready    <= 1'b1;
		end else if (data_strobe) begin
			shiftreg <= {1'b1, data, 1'b0}; // stop, data, start
			ready    <= 1'b0;
			// frame begins on the next baud_x1
		end else if (baud_x1) begin
			if (shiftreg == '0) begin
				serial_r <= 1'b0; // idle, line high
				ready    <= 1'b1; // stop bit has been on the line a full bit
			end else begin
				serial_r <= !shiftreg[0]; // next bit onto the line
			end
			shiftreg <= {1'b0, shiftreg[uart_pkg::byte_width+1:1]}; // lsb first
		end
	end

	// frame is 10 bit periods plus one period of latency through serial_r
	// ready stays low until the shift register drains on a baud_x1
	// so consecutive frames have one idle bit between them
	// a load that lands on a baud_x1 wins, the shift waits a bit

endmodule

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
	parameter int fifo_depth = 8,                   // power of two
	parameter int width      = uart_pkg::byte_width // entry width
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [width-1:0] write_data,
	input  logic             write_strobe,   // ignored when full
	input  logic             read_strobe,    // ignored when empty
	output logic [width-1:0] read_data,      // valid the cycle after read_strobe
	output logic             data_available,
	output logic             space_available
);

	localparam int ptr_w = $clog2(fifo_depth);
	localparam int cnt_w = $clog2(fifo_depth + 1);

	logic [width-1:0] mem [fifo_depth]; // circular buffer
	logic [ptr_w-1:0] wr_ptr;           // next slot to write
	logic [ptr_w-1:0] rd_ptr;           // oldest entry
	logic [cnt_w-1:0] count;            // occupancy
	logic             do_write;
	logic             do_read;

	assign data_available  = (count != '0);
	assign space_available = (count != cnt_w'(fifo_depth));

	assign do_write = write_strobe && space_available; // full fifo drops the byte
	assign do_read  = read_strobe && data_available;

	// pointers and occupancy
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			// read and write together leave count alone
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	// storage and registered read port
	always_ff @(posedge clk) begin
		if (do_write)
			mem[wr_ptr] <= write_data;
		if (do_read)
			read_data <= mem[rd_ptr]; // holds last popped value otherwise
	end

	// a full fifo with a read and a write in one cycle drops the write
	// the caller sees that through space_available

endmodule

// ==== verilog/baud_gen.sv ====
`timescale 1ns/1ps

module baud_gen #(
	parameter int baud_div = 4 // clk cycles per baud_x4 strobe, at least 2
) (
	input  logic clk,
	input  logic reset,
	output logic baud_x4, // one cycle pulse every baud_div clocks
	output logic baud_x1  // coincides with every fourth baud_x4
);

	localparam int cnt_w = $clog2(baud_div);

	logic [cnt_w-1:0] div_cnt; // counts down to zero then reloads
	logic [1:0]       phase;   // quarter-bit position within a bit period
	logic             tick;    // divider wraps this cycle

	assign tick = (div_cnt == '0);

	// divider and phase counter, outputs are registered pulses
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			div_cnt <= cnt_w'(baud_div - 1); // first strobe baud_div cycles after release
			phase   <= 2'd0;
			baud_x4 <= 1'b0;
			baud_x1 <= 1'b0;
		end else begin
			baud_x4 <= tick;
			baud_x1 <= tick && (phase == 2'd3); // last quarter of the bit
			if (tick) begin
				div_cnt <= cnt_w'(baud_div - 1); // reload
				phase   <= phase + 2'd1;         // wraps every four strobes
			end else begin
				div_cnt <= div_cnt - 1'b1;
			end
		end
	end

	// one bit period is 4 * baud_div clocks

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

	// serial byte and bus data width
	localparam int byte_width = 8;

	// register map, two address bits on the bus
	localparam logic [1:0] adr_data   = 2'd0; // write queues tx byte, read pops rx byte
	localparam logic [1:0] adr_status = 2'd1; // read only, clears overflow on read
	// addresses 2 and 3 are unmapped and read as zero

	// bit positions in the status word
	localparam int stat_tx_space = 0; // tx fifo can take another byte
	localparam int stat_rx_avail = 1; // rx fifo holds at least one byte
	localparam int stat_rx_ovf   = 2; // sticky, a received byte was lost

	// remaining status bits read as zero

	// frame layout shared by tx and rx
	// start bit, byte_width data bits lsb first, one stop bit
	// no parity bit, no break detection

	// line idles high on both txd and rxd

	// one bit period is four baud_x4 strobes
	// one baud_x1 strobe per bit period

endpackage
